// ==== source/vpu_cfg.svh ====
// lane geometry and byte saturation bounds for the vector unit
`ifndef VPU_CFG_SVH
`define VPU_CFG_SVH

// four byte lanes packed in one word
`define VPU_LANES   4
`define VPU_LANE_W  8

// lane results carry a full 16-bit product
`define VPU_WIDE_W  16
`define VPU_WORD_W  32

// clip bounds for signed and unsigned bytes
`define VPU_SMAX    127
`define VPU_SMIN    (-128)
`define VPU_UMAX    255

`endif

// ==== source/vpu_pkg.sv ====
// vector word union, lane and reduction opcode types, byte clip function
package vpu_pkg;

    `include "vpu_cfg.svh"

    // same 32 bits, seen as a word or as four byte lanes (lane 0 low)
    typedef union packed {
        logic [`VPU_WORD_W-1:0]                 word;
        logic [`VPU_LANES-1:0][`VPU_LANE_W-1:0] lanes;
    } vec_word_u;

    typedef logic [`VPU_LANES-1:0][`VPU_WIDE_W-1:0] wide_lanes_t;

    // wide enough for an unsigned sum of four 16-bit lanes, plus sign
    typedef logic signed [19:0] acc_t;

    typedef enum logic [2:0] {
        LF_PASS_A = 3'b000,
        LF_ADD    = 3'b001,
        LF_SUB    = 3'b010,
        LF_MUL    = 3'b011,
        LF_MOVB   = 3'b100,
        LF_MAX    = 3'b101,
        LF_MIN    = 3'b110,
        LF_XOR    = 3'b111
    } lane_func_e;

    typedef struct packed {
        logic       is_unsigned;
        logic       sat;
        lane_func_e func;
    } lane_op_t;

    // pack with red_unsigned set means byte xor
    typedef enum logic [1:0] {
        RF_PACK = 2'b00,
        RF_SUM  = 2'b01,
        RF_MAX  = 2'b10,
        RF_MIN  = 2'b11
    } red_func_e;

    typedef struct packed {
        logic      red_unsigned;
        red_func_e red_func;
    } red_op_t;

    // clip to byte range, 0..255 or -128..127
    function automatic acc_t sat_byte(input acc_t v, input logic is_unsigned);
        acc_t hi;
        acc_t lo;
        hi = is_unsigned ? acc_t'(`VPU_UMAX) : acc_t'(`VPU_SMAX);
        lo = is_unsigned ? acc_t'(0) : acc_t'(`VPU_SMIN);
        if (v > hi)
            return hi;
        else if (v < lo)
            return lo;
        return v;
    endfunction

endpackage

// ==== source/vpu_stage_if.sv ====
// stage interfaces: operand_if into the lane stage, lane_if into the reduce stage
`timescale 1ns/1ns

// registered operands and opcodes after the input stage
interface operand_if import vpu_pkg::*; ();
    vec_word_u ra;
    vec_word_u rb;
    lane_op_t  lane_op;
    red_op_t   red_op;
    logic      issue;

    modport src (
        output ra, rb, lane_op, red_op, issue
    );

    modport dst (
        input ra, rb, lane_op, red_op, issue
    );
endinterface

// registered 16-bit lane results after the lane stage
interface lane_if import vpu_pkg::*; ();
    wide_lanes_t lanes;
    red_op_t     red_op;
    // saturate flag of the lane op, reused by the sum reduction
    logic        sat;
    logic        issue;

    modport src (
        output lanes, red_op, sat, issue
    );

    modport dst (
        input lanes, red_op, sat, issue
    );
endinterface

// ==== source/vpu_operand_reg.sv ====
// input stage: operand, opcode and issue registers
`timescale 1ns/1ns
`include "vpu_cfg.svh"

module vpu_operand_reg import vpu_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   holdn,
    input  logic [`VPU_WORD_W-1:0] ra,
    input  logic [`VPU_WORD_W-1:0] rb,
    input  lane_op_t               lane_op,
    input  red_op_t                red_op,
    input  logic                   issue,
    operand_if.src                 op_if
);

    // operands enter as words, the lane stage reads them as bytes
    always_ff @(posedge clk) begin
        if (!rstn) begin
            op_if.ra.word <= '0;
            op_if.rb.word <= '0;
        end else if (holdn) begin
            op_if.ra.word <= ra;
            op_if.rb.word <= rb;
        end
    end

    // opcodes follow the operands
    always_ff @(posedge clk) begin
        if (!rstn) begin
            op_if.lane_op <= '0;
            op_if.red_op  <= '0;
        end else if (holdn) begin
            op_if.lane_op <= lane_op;
            op_if.red_op  <= red_op;
        end
    end

    // issue strobe, only taken on a non-stalled edge
    always_ff @(posedge clk) begin
        if (!rstn) begin
            op_if.issue <= 1'b0;
        end else if (holdn) begin
            op_if.issue <= issue;
        end
    end

endmodule

// ==== source/vpu_lane_alu.sv ====
// single lane ALU: add, sub, multiply, max, min, xor with byte saturation
`timescale 1ns/1ns
`include "vpu_cfg.svh"

module vpu_lane_alu import vpu_pkg::*; (
    input  logic [`VPU_LANE_W-1:0] a,
    input  logic [`VPU_LANE_W-1:0] b,
    input  lane_op_t               lane_op,
    output logic [`VPU_WIDE_W-1:0] y
);

    logic                        sgn;
    logic signed [`VPU_LANE_W:0] ax;
    logic signed [`VPU_LANE_W:0] bx;
    logic signed [`VPU_LANE_W:0] max_v;
    logic signed [`VPU_LANE_W:0] min_v;
    logic                        a_gt_b;
    acc_t                        sum_v;
    acc_t                        diff_v;
    acc_t                        prod_v;
    acc_t                        arith;
    acc_t                        clipped;

    // 9-bit lane value with sign bit, sign extended result to 16 bits
    function automatic logic [`VPU_WIDE_W-1:0] widen(input logic signed [`VPU_LANE_W:0] v);
        return `VPU_WIDE_W'(v);
    endfunction

    assign sgn = ~lane_op.is_unsigned;

    // extra top bit makes signed and unsigned both fit a signed compare
    assign ax = {sgn & a[`VPU_LANE_W-1], a};
    assign bx = {sgn & b[`VPU_LANE_W-1], b};

    // exact results, no overflow at this width
    assign sum_v  = acc_t'(ax) + acc_t'(bx);
    assign diff_v = acc_t'(ax) - acc_t'(bx);
    assign prod_v = acc_t'(ax) * acc_t'(bx);

    assign a_gt_b = ax > bx;
    assign max_v  = a_gt_b ? ax : bx;
    assign min_v  = a_gt_b ? bx : ax;

    // arithmetic result feeding the clip logic
    always_comb begin
        case (lane_op.func)
            LF_ADD:  arith = sum_v;
            LF_SUB:  arith = diff_v;
            default: arith = prod_v;
        endcase
    end

    assign clipped = sat_byte(arith, lane_op.is_unsigned);

    always_comb begin
        case (lane_op.func)
            LF_PASS_A: begin
                y = widen(ax);
            end
            LF_ADD, LF_SUB, LF_MUL: begin
                // wrap to the low 16 bits unless saturating
                if (lane_op.sat)
                    y = clipped[`VPU_WIDE_W-1:0];
                else
                    y = arith[`VPU_WIDE_W-1:0];
            end
            LF_MOVB: begin
                y = widen(bx);
            end
            LF_MAX: begin
                y = widen(max_v);
            end
            LF_MIN: begin
                y = widen(min_v);
            end
            default: begin
                // xor is always zero extended
                y = `VPU_WIDE_W'(a ^ b);
            end
        endcase
    end

endmodule

// ==== source/vpu_lane_stage.sv ====
// lane stage: four lane ALUs and the stage-2 register
`timescale 1ns/1ns
`include "vpu_cfg.svh"

module vpu_lane_stage import vpu_pkg::*; (
    input  logic   clk,
    input  logic   rstn,
    input  logic   holdn,
    operand_if.dst op_if,
    lane_if.src    ln_if
);

    wide_lanes_t lanes_next;

    // one ALU per byte lane, all sharing the same opcode
    for (genvar i = 0; i < `VPU_LANES; i++) begin : g_lane
        vpu_lane_alu u_alu (
            .a       (op_if.ra.lanes[i]),
            .b       (op_if.rb.lanes[i]),
            .lane_op (op_if.lane_op),
            .y       (lanes_next[i])
        );
    end

    // lane results
    always_ff @(posedge clk) begin
        if (!rstn) begin
            ln_if.lanes <= '0;
        end else if (holdn) begin
            ln_if.lanes <= lanes_next;
        end
    end

    // reduction op, sat flag and issue move along with the lanes
    always_ff @(posedge clk) begin
        if (!rstn) begin
            ln_if.red_op <= '0;
            ln_if.sat    <= 1'b0;
            ln_if.issue  <= 1'b0;
        end else if (holdn) begin
            ln_if.red_op <= op_if.red_op;
            ln_if.sat    <= op_if.lane_op.sat;
            ln_if.issue  <= op_if.issue;
        end
    end

endmodule

// ==== source/vpu_reduce.sv ====
// reduce stage: pack, sum, max, min and xor of the lanes, result register
`timescale 1ns/1ns
`include "vpu_cfg.svh"

module vpu_reduce import vpu_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   holdn,
    lane_if.dst                    ln_if,
    output logic [`VPU_WORD_W-1:0] result,
    output logic                   result_valid
);

    logic                        sgn;
    logic signed [`VPU_WIDE_W:0] lx [`VPU_LANES];
    logic signed [`VPU_WIDE_W:0] max_v;
    logic signed [`VPU_WIDE_W:0] min_v;
    acc_t                        sum_v;
    logic [`VPU_LANE_W-1:0]      xor_v;
    vec_word_u                   pack_v;
    logic [`VPU_WORD_W-1:0]      red_word;

    assign sgn = ~ln_if.red_op.red_unsigned;

    // lane extension, sum, xor and pack in one pass
    always_comb begin
        sum_v = '0;
        xor_v = '0;
        for (int i = 0; i < `VPU_LANES; i++) begin
            lx[i] = {sgn & ln_if.lanes[i][`VPU_WIDE_W-1], ln_if.lanes[i]};
            sum_v = sum_v + acc_t'(lx[i]);
            xor_v = xor_v ^ ln_if.lanes[i][`VPU_LANE_W-1:0];
            pack_v.lanes[i] = ln_if.lanes[i][`VPU_LANE_W-1:0];
        end
    end

    // extremal lane search
    always_comb begin
        max_v = lx[0];
        min_v = lx[0];
        for (int i = 1; i < `VPU_LANES; i++) begin
            if (lx[i] > max_v)
                max_v = lx[i];
            if (lx[i] < min_v)
                min_v = lx[i];
        end
    end

    always_comb begin
        case (ln_if.red_op.red_func)
            RF_SUM: begin
                if (ln_if.sat)
                    red_word = `VPU_WORD_W'(sat_byte(sum_v, ln_if.red_op.red_unsigned));
                else
                    red_word = `VPU_WORD_W'(sum_v);
            end
            RF_MAX: begin
                red_word = `VPU_WORD_W'(max_v);
            end
            RF_MIN: begin
                red_word = `VPU_WORD_W'(min_v);
            end
            default: begin
                // unsigned pack code selects the byte xor
                if (ln_if.red_op.red_unsigned)
                    red_word = `VPU_WORD_W'(xor_v);
                else
                    red_word = pack_v.word;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            result       <= '0;
            result_valid <= 1'b0;
        end else if (holdn) begin
            result       <= red_word;
            result_valid <= ln_if.issue;
        end
    end

endmodule

// ==== source/vpu_top.sv ====
// top level of the SIMD byte-vector unit, three pipeline stages
`timescale 1ns/1ns
`include "vpu_cfg.svh"

module vpu_top import vpu_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   holdn,
    input  logic [`VPU_WORD_W-1:0] ra,
    input  logic [`VPU_WORD_W-1:0] rb,
    input  lane_op_t               lane_op,
    input  red_op_t                red_op,
    input  logic                   issue,
    output logic [`VPU_WORD_W-1:0] result,
    output logic                   result_valid
);

    operand_if opif ();
    lane_if    lnif ();

    // stage 1, input registers
    vpu_operand_reg u_operand_reg (
        .clk     (clk),
        .rstn    (rstn),
        .holdn   (holdn),
        .ra      (ra),
        .rb      (rb),
        .lane_op (lane_op),
        .red_op  (red_op),
        .issue   (issue),
        .op_if   (opif)
    );

    // stage 2, lane ALUs
    vpu_lane_stage u_lane_stage (
        .clk   (clk),
        .rstn  (rstn),
        .holdn (holdn),
        .op_if (opif),
        .ln_if (lnif)
    );

    // stage 3, reduction and result
    vpu_reduce u_reduce (
        .clk          (clk),
        .rstn         (rstn),
        .holdn        (holdn),
        .ln_if        (lnif),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

// ==== tb/vpu_monitor.sv ====
// result monitor: expected-result queue with value and latency compare
`timescale 1ns/1ns
`include "vpu_cfg.svh"

module vpu_monitor (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   holdn,
    input  logic                   push,
    input  logic [`VPU_WORD_W-1:0] exp_word,
    input  int                     exp_tag,
    input  logic [`VPU_WORD_W-1:0] result,
    input  logic                   result_valid,
    output int                     pass_count,
    output int                     fail_count,
    output int                     pending
);

    // enabled edges from capture to the edge that first sees the result
    localparam int LATENCY = 3;

    logic [`VPU_WORD_W-1:0] exp_q[$];
    int                     tag_q[$];
    int                     stamp_q[$];
    int                     edge_cnt;

    always @(posedge clk) begin : compare
        logic [`VPU_WORD_W-1:0] want;
        int                     tag;
        int                     age;
        if (rstn && holdn && result_valid) begin
            if (exp_q.size() == 0) begin
                fail_count++;
                $display("result_valid high with no operation outstanding, result 0x%08h",
                         result);
            end else begin
                want = exp_q.pop_front();
                tag  = tag_q.pop_front();
                age  = edge_cnt - stamp_q.pop_front();
                if (result !== want) begin
                    fail_count++;
                    $display("[FAIL] test %0d result got 0x%08h expected 0x%08h",
                             tag, result, want);
                end else if (age != LATENCY) begin
                    fail_count++;
                    $display("test %0d: result came %0d enabled edges after capture, not %0d",
                             tag, age, LATENCY);
                end else begin
                    pass_count++;
                    $display("[PASS] test %0d result 0x%08h", tag, result);
                end
            end
        end
        // new capture, stamped with the current enabled-edge count
        if (rstn && push) begin
            exp_q.push_back(exp_word);
            tag_q.push_back(exp_tag);
            stamp_q.push_back(edge_cnt);
        end
        if (rstn && holdn)
            edge_cnt++;
        pending = exp_q.size();
    end

endmodule

// ==== tb/vpu_checker.sv ====
// concurrent assertions on reset, stall and issue behavior, bound into vpu_top
`timescale 1ns/1ns
`include "vpu_cfg.svh"

module vpu_checker (
    input logic                   clk,
    input logic                   rstn,
    input logic                   holdn,
    input logic                   issue,
    input logic [`VPU_WORD_W-1:0] result,
    input logic                   result_valid
);

    int   fail_count;
    logic issue_seen;

    // set once an issue is taken on an enabled edge
    always_ff @(posedge clk) begin
        if (!rstn) begin
            issue_seen <= 1'b0;
        end else if (holdn && issue) begin
            issue_seen <= 1'b1;
        end
    end

    // output clear in reset and one edge beyond
    a_reset_quiet: assert property (@(posedge clk) !rstn |=> !result_valid ##1 !result_valid)
        else begin
            fail_count++;
            $error("result_valid set during or just after reset");
        end

    // a stalled edge changes nothing at the output
    a_hold_stable: assert property (@(posedge clk) disable iff (!rstn)
        !holdn |=> $stable(result) && $stable(result_valid))
        else begin
            fail_count++;
            $error("result or result_valid changed across a stalled edge");
        end

    a_valid_after_issue: assert property (@(posedge clk) disable iff (!rstn)
        $rose(result_valid) |-> issue_seen)
        else begin
            fail_count++;
            $error("result_valid rose before any issue was taken");
        end

endmodule

bind vpu_top vpu_checker chk0 (
    .clk          (clk),
    .rstn         (rstn),
    .holdn        (holdn),
    .issue        (issue),
    .result       (result),
    .result_valid (result_valid)
);

// ==== tb/vpu_tb.sv ====
// testbench top with clock, reset, LFSR-filled stimulus table, reference model and final report
`timescale 1ns/1ns
`include "vpu_cfg.svh"

module vpu_tb import vpu_pkg::*; ();

    typedef struct {
        logic [31:0] ra;
        logic [31:0] rb;
        lane_op_t    lop;
        red_op_t     rop;
        logic        issue;
        logic        holdn;
        logic [31:0] exp;
    } row_t;

    logic                   clk;
    logic                   rstn;
    logic                   holdn;
    logic [`VPU_WORD_W-1:0] ra;
    logic [`VPU_WORD_W-1:0] rb;
    lane_op_t               lane_op;
    red_op_t                red_op;
    logic                   issue;
    logic [`VPU_WORD_W-1:0] result;
    logic                   result_valid;
    logic                   push;
    logic [`VPU_WORD_W-1:0] exp_word;
    int                     exp_tag;
    int                     pass_count;
    int                     fail_count;
    int                     pending;
    row_t                   table_q[$];
    logic [31:0]            lfsr = 32'h9ec482c7;

    vpu_top dut0 (.*);

    vpu_monitor mon0 (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one LFSR step for every output bit
    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic int clip_byte(input int v, input logic uns);
        int hi;
        int lo;
        hi = uns ? 255 : 127;
        lo = uns ? 0 : -128;
        return (v > hi) ? hi : ((v < lo) ? lo : v);
    endfunction

    function automatic logic [15:0] model_lane(input logic [7:0] a, input logic [7:0] b,
                                               input lane_op_t op);
        int av;
        int bv;
        int r;
        av = op.is_unsigned ? int'(a) : int'($signed(a));
        bv = op.is_unsigned ? int'(b) : int'($signed(b));
        case (op.func)
            LF_PASS_A: r = av;
            LF_ADD:    r = av + bv;
            LF_SUB:    r = av - bv;
            LF_MUL:    r = av * bv;
            LF_MOVB:   r = bv;
            LF_MAX:    r = (av > bv) ? av : bv;
            LF_MIN:    r = (av < bv) ? av : bv;
            default:   r = int'(a ^ b);
        endcase
        if (op.sat && op.func inside {LF_ADD, LF_SUB, LF_MUL})
            r = clip_byte(r, op.is_unsigned);
        return r[15:0];
    endfunction

    function automatic logic [31:0] model_result(input logic [31:0] a, input logic [31:0] b,
                                                 input lane_op_t lo, input red_op_t ro);
        logic [15:0] y;
        logic [31:0] pk;
        logic [7:0]  x;
        int          v;
        int          sum;
        int          mx;
        int          mn;
        sum = 0;
        x = '0;
        for (int i = 0; i < `VPU_LANES; i++) begin
            y = model_lane(a[8*i +: 8], b[8*i +: 8], lo);
            v = ro.red_unsigned ? int'(y) : int'($signed(y));
            sum += v;
            x ^= y[7:0];
            pk[8*i +: 8] = y[7:0];
            mx = (i == 0 || v > mx) ? v : mx;
            mn = (i == 0 || v < mn) ? v : mn;
        end
        case (ro.red_func)
            RF_SUM:  return lo.sat ? clip_byte(sum, ro.red_unsigned) : sum;
            RF_MAX:  return mx;
            RF_MIN:  return mn;
            default: return ro.red_unsigned ? {24'h0, x} : pk;
        endcase
    endfunction

    function automatic lane_op_t lop(input logic uns, input logic sat, input lane_func_e f);
        return '{uns, sat, f};
    endfunction

    function automatic red_op_t rop(input logic uns, input red_func_e f);
        return '{uns, f};
    endfunction

    task automatic op_row(input logic [31:0] a, input logic [31:0] b, input lane_op_t lo,
                          input red_op_t ro, input logic [31:0] e);
        table_q.push_back('{a, b, lo, ro, 1'b1, 1'b1, e});
    endtask

    // idle row, or a stalled row whose issue must be ignored
    task automatic gap_row(input logic hn);
        table_q.push_back('{32'hffffffff, 32'h7f7f7f7f, lop(0, 1, LF_MUL), rop(0, RF_SUM),
                            !hn, hn, '0});
    endtask

    task automatic rand_row();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] f;
        lane_op_t    lo;
        red_op_t     ro;
        draw_bits(32, a);
        draw_bits(32, b);
        draw_bits(8, f);
        lo = lop(f[0], f[1], lane_func_e'(f[4:2]));
        ro = rop(f[5], red_func_e'(f[7:6]));
        op_row(a, b, lo, ro, model_result(a, b, lo, ro));
    endtask

    task automatic build_table();
        gap_row(1'b1);
        gap_row(1'b1);
        op_row(32'h807f01fe, 32'h11223344, lop(0, 0, LF_PASS_A), rop(0, RF_PACK), 32'h807f01fe);
        op_row(32'h807f01fe, 32'h11223344, lop(1, 0, LF_MOVB), rop(0, RF_PACK), 32'h11223344);
        op_row(32'h7f800110, 32'h0180ff20, lop(0, 0, LF_ADD), rop(0, RF_PACK), 32'h80000030);
        op_row(32'h7f800110, 32'h0180ff20, lop(0, 1, LF_ADD), rop(0, RF_PACK), 32'h7f800030);
        op_row(32'hff800110, 32'h0180ff20, lop(1, 1, LF_ADD), rop(0, RF_PACK), 32'hffffff30);
        op_row(32'h001005ff, 32'h01200301, lop(1, 0, LF_SUB), rop(0, RF_PACK), 32'hfff002fe);
        op_row(32'h001005ff, 32'h01200301, lop(1, 1, LF_SUB), rop(0, RF_PACK), 32'h000002fe);
        op_row(32'h807f0510, 32'h01ff10f0, lop(0, 1, LF_SUB), rop(0, RF_PACK), 32'h807ff520);
        gap_row(1'b0);
        gap_row(1'b0);
        op_row(32'h80f00710, 32'h80030910, lop(0, 0, LF_MUL), rop(0, RF_PACK), 32'h00d03f00);
        op_row(32'h80f00710, 32'h80030910, lop(0, 1, LF_MUL), rop(0, RF_PACK), 32'h7fd03f7f);
        op_row(32'h03f00710, 32'h80030910, lop(1, 1, LF_MUL), rop(0, RF_PACK), 32'hffff3fff);
        op_row(32'h807f05f0, 32'h7f80fb10, lop(0, 0, LF_MAX), rop(0, RF_PACK), 32'h7f7f0510);
        op_row(32'h807f05f0, 32'h7f80fb10, lop(1, 0, LF_MAX), rop(0, RF_PACK), 32'h8080fbf0);
        op_row(32'h807f05f0, 32'h7f80fb10, lop(0, 0, LF_MIN), rop(0, RF_PACK), 32'h8080fbf0);
        op_row(32'ha50fff12, 32'h5af00f34, lop(0, 0, LF_XOR), rop(0, RF_PACK), 32'hfffff026);
        // reductions
        op_row(32'h807fff10, 32'h00000000, lop(0, 0, LF_PASS_A), rop(0, RF_SUM), 32'h0000000e);
        op_row(32'h807fff10, 32'h00000000, lop(1, 0, LF_PASS_A), rop(1, RF_SUM), 32'h0000020e);
        gap_row(1'b0);
        op_row(32'h80808080, 32'h80808080, lop(0, 0, LF_ADD), rop(0, RF_SUM), 32'hfffffc00);
        op_row(32'h80808080, 32'h80808080, lop(0, 1, LF_ADD), rop(0, RF_SUM), 32'hffffff80);
        op_row(32'h80706050, 32'h00000000, lop(1, 1, LF_PASS_A), rop(1, RF_SUM), 32'h000000ff);
        op_row(32'h80f00710, 32'h80030910, lop(0, 0, LF_MUL), rop(0, RF_MAX), 32'h00004000);
        op_row(32'h80f00710, 32'h80030910, lop(0, 0, LF_MUL), rop(0, RF_MIN), 32'hffffffd0);
        op_row(32'h80f00710, 32'h80030910, lop(0, 0, LF_MUL), rop(1, RF_MAX), 32'h0000ffd0);
        op_row(32'h80f00710, 32'h80030910, lop(0, 0, LF_MUL), rop(1, RF_MIN), 32'h0000003f);
        op_row(32'ha50fff12, 32'h5af00f34, lop(0, 0, LF_XOR), rop(1, RF_PACK), 32'h000000d6);
        repeat (8) rand_row();
        gap_row(1'b0);
    endtask

    task automatic apply_row(input int i);
        ra       = table_q[i].ra;
        rb       = table_q[i].rb;
        lane_op  = table_q[i].lop;
        red_op   = table_q[i].rop;
        issue    = table_q[i].issue;
        holdn    = table_q[i].holdn;
        push     = table_q[i].issue && table_q[i].holdn;
        exp_word = table_q[i].exp;
        exp_tag  = i;
    endtask

    initial begin
        int   waited;
        int   issued;
        int   chk_fails;
        logic timed_out;
        rstn     = 1'b0;
        holdn    = 1'b1;
        ra       = '0;
        rb       = '0;
        lane_op  = '0;
        red_op   = '0;
        issue    = 1'b0;
        push     = 1'b0;
        exp_word = '0;
        exp_tag  = 0;
        issued   = 0;
        build_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        foreach (table_q[i]) begin
            @(negedge clk);
            apply_row(i);
            issued += push;
        end
        @(negedge clk);
        holdn = 1'b1;
        issue = 1'b0;
        push  = 1'b0;
        // drain the pipeline
        waited = 0;
        while (pending != 0 && waited < 50) begin
            @(negedge clk);
            waited++;
        end
        timed_out = (pending != 0);
        if (timed_out)
            $display("timeout: %0d results still outstanding after %0d cycles", pending, waited);
        // idle edges where a spurious result would still be caught
        repeat (4) @(negedge clk);
        chk_fails = dut0.chk0.fail_count;
        if (pass_count + fail_count != issued)
            $display("%0d results checked for %0d issued operations",
                     pass_count + fail_count, issued);
        $display("tests: %0d passed, %0d failed, %0d assertion failures",
                 pass_count, fail_count, chk_fails);
        if (!timed_out && fail_count == 0 && chk_fails == 0 && pass_count == issued)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+source
source/vpu_pkg.sv
source/vpu_stage_if.sv
source/vpu_operand_reg.sv
source/vpu_lane_alu.sv
source/vpu_lane_stage.sv
source/vpu_reduce.sv
source/vpu_top.sv
tb/vpu_monitor.sv
tb/vpu_checker.sv
tb/vpu_tb.sv
